/* rtl/tx_bit_pkg.sv */
// shared sizes, vector types, descriptor layout and scheduler states
package tx_bit_pkg;

    // access-category queues
    localparam int num_queues = 4;
    // descriptor entries per queue
    localparam int desc_depth = 64;
    // stream and buffer word width
    localparam int dma_word_w = 64;
    // packet buffer address width
    localparam int buf_addr_w = 10;
    // cycles that start stays high
    localparam int start_pulse_len = 6;

    typedef logic [1:0] queue_idx_t;
    typedef logic [dma_word_w-1:0] dma_word_t;
    typedef logic [buf_addr_w-1:0] buf_addr_t;
    // occupancy 0..desc_depth, one bit wider than the pointer
    typedef logic [6:0] fifo_count_t;
    typedef logic [12:0] num_symbol_t;
    typedef logic [9:0] seq_num_t;
    typedef logic [1:0] prio_t;

    // fifo pointers wrap on their own, depth is a power of two
    typedef logic [$clog2(desc_depth)-1:0] fifo_ptr_t;
    // down-counter for the start pulse
    typedef logic [$clog2(start_pulse_len+1)-1:0] pulse_cnt_t;

    // one descriptor per frame, written by the host
    // prio and seq_num only matter on the completion latch
    typedef struct packed {
        prio_t       prio;
        seq_num_t    seq_num;
        logic [1:0]  reserved;
        logic [3:0]  retrans_limit;
        logic        need_ack;
        num_symbol_t num_symbol;
    } tx_desc_t;

    // idle   wait for an allowed non-empty queue
    // fetch  pop issued, fifo read in flight
    // load   head valid, capture it
    // do_tx  copy stream words until tx_end
    typedef enum logic [1:0] {
        idle,
        fetch,
        load,
        do_tx
    } sched_state_t;

endpackage

/* rtl/tx_desc_fifo.sv */
// single-clock descriptor fifo with registered read data and occupancy count
`timescale 1ns/10ps

module tx_desc_fifo import tx_bit_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        wr_en,
    input  tx_desc_t    wr_data,
    input  logic        rd_en,
    output tx_desc_t    rd_data,
    output logic        empty,
    output logic        full,
    output fifo_count_t count
);

    // descriptor storage
    tx_desc_t mem [desc_depth];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;

    // qualified requests
    logic do_wr;
    logic do_rd;

    assign empty = (count == '0);
    assign full  = (count == fifo_count_t'(desc_depth));

    // write to full and read from empty are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // storage write, no reset on the array
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // read data lands one cycle after rd_en
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

    // pointers and occupancy
    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // simultaneous push and pop keep the count
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rtl/tx_desc_queues.sv */
// four access-category descriptor fifos with strobe edge detect and head mux
`timescale 1ns/10ps

module tx_desc_queues import tx_bit_pkg::*; (
    input  logic                         clk,
    input  logic                         rstn,
    input  logic                         recv_done_strobe,
    input  queue_idx_t                   wr_queue,
    input  tx_desc_t                     wr_desc,
    input  logic [num_queues-1:0]        pop,
    output logic [num_queues-1:0]        empty,
    output tx_desc_t                     head,
    output fifo_count_t [num_queues-1:0] counts
);

    // strobe history for the falling edge
    logic strobe_d;
    logic strobe_fall;

    // per-queue write enables, one-hot
    logic [num_queues-1:0] wr_en_q;
    // descriptor held alongside the write enable
    tx_desc_t wr_desc_q;

    // which queue was popped last
    queue_idx_t pop_idx;
    queue_idx_t pop_sel;

    tx_desc_t fifo_rd [num_queues];

    // host signals dma done with high-to-low
    assign strobe_fall = strobe_d && !recv_done_strobe;

    // one-hot pop to queue number
    always_comb begin
        pop_idx = '0;
        for (int i = 0; i < num_queues; i++) begin
            if (pop[i]) begin
                pop_idx = queue_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            strobe_d <= 1'b0;
            wr_en_q  <= '0;
            pop_sel  <= '0;
        end else begin
            strobe_d <= recv_done_strobe;
            // steer the write to the named queue only
            for (int i = 0; i < num_queues; i++) begin
                wr_en_q[i] <= strobe_fall && (wr_queue == queue_idx_t'(i));
            end
            // remember source of the pending read
            if (|pop) begin
                pop_sel <= pop_idx;
            end
        end
    end

    // payload follows the enable
    always_ff @(posedge clk) begin
        wr_desc_q <= wr_desc;
    end

    // head is valid a cycle after the pop
    assign head = fifo_rd[pop_sel];

    for (genvar g = 0; g < num_queues; g++) begin : g_queue
        tx_desc_fifo i_fifo (
            .clk     (clk),
            .rstn    (rstn),
            .wr_en   (wr_en_q[g]),
            .wr_data (wr_desc_q),
            .rd_en   (pop[g]),
            .rd_data (fifo_rd[g]),
            .empty   (empty[g]),
            .full    (),
            .count   (counts[g])
        );
    end

endmodule

/* rtl/tx_queue_sched.sv */
// queue scheduler fsm, dma word copy into the buffer, start pulse, completion latch
`timescale 1ns/10ps

module tx_queue_sched import tx_bit_pkg::*; (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [num_queues-1:0] allowed,
    input  logic [num_queues-1:0] empty,
    output logic [num_queues-1:0] pop,
    input  tx_desc_t              head,
    input  logic                  bb_busy,
    input  logic                  tx_end,
    input  logic                  try_complete,
    input  logic                  auto_start,
    input  buf_addr_t             start_th,
    input  dma_word_t             s_data,
    input  logic                  s_emptyn,
    output logic                  s_ask,
    output logic                  buf_we,
    output buf_addr_t             buf_waddr,
    output dma_word_t             buf_wdata,
    output queue_idx_t            queue_idx,
    output logic                  need_ack,
    output logic [3:0]            retrans_limit,
    output seq_num_t              seq_num,
    output prio_t                 prio,
    output logic                  start
);

    sched_state_t state;

    // descriptor of the frame being served
    tx_desc_t cur_desc;
    // words accepted so far in this frame
    num_symbol_t wr_cnt;

    // fixed-priority pick
    logic       sel_valid;
    queue_idx_t sel_idx;

    // stream handshake
    logic accept;
    logic last_word;

    // start stretch
    pulse_cnt_t pulse_cnt;
    logic       th_hit;

    // lowest queue number wins, scan from the top down
    always_comb begin
        sel_valid = 1'b0;
        sel_idx   = '0;
        for (int i = num_queues - 1; i >= 0; i--) begin
            if (allowed[i] && !empty[i]) begin
                sel_valid = 1'b1;
                sel_idx   = queue_idx_t'(i);
            end
        end
    end

    // word taken whenever ask and emptyn meet
    assign accept    = s_ask && s_emptyn;
    assign last_word = accept && (wr_cnt == cur_desc.num_symbol - num_symbol_t'(1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state     <= idle;
            pop       <= '0;
            queue_idx <= '0;
            cur_desc  <= '0;
            s_ask     <= 1'b0;
            wr_cnt    <= '0;
            buf_we    <= 1'b0;
        end else begin
            // pop is a single-cycle strobe
            pop    <= '0;
            buf_we <= accept;
            unique case (state)
                idle: begin
                    s_ask  <= 1'b0;
                    wr_cnt <= '0;
                    // hold off while the baseband is still sending
                    if (sel_valid && !bb_busy) begin
                        queue_idx      <= sel_idx;
                        pop[sel_idx]   <= 1'b1;
                        state          <= fetch;
                    end
                end
                fetch: begin
                    // fifo read in flight
                    state <= load;
                end
                load: begin
                    cur_desc <= head;
                    // empty frame never asks
                    s_ask    <= (head.num_symbol != '0);
                    state    <= do_tx;
                end
                do_tx: begin
                    if (accept) begin
                        wr_cnt <= wr_cnt + 1'b1;
                    end
                    // stop right after the last announced word
                    if (last_word || tx_end) begin
                        s_ask <= 1'b0;
                    end
                    if (tx_end) begin
                        state <= idle;
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // buffer write lags the accepted word by one cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            buf_waddr <= wr_cnt[buf_addr_w-1:0];
            buf_wdata <= s_data;
        end
    end

    // threshold word has just gone into the buffer
    assign th_hit = buf_we && (buf_waddr == start_th);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pulse_cnt <= '0;
            seq_num   <= '0;
            prio      <= '0;
        end else begin
            if (th_hit && auto_start) begin
                pulse_cnt <= pulse_cnt_t'(start_pulse_len);
            end else if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - 1'b1;
            end
            // host reads these back after the attempt
            if (try_complete) begin
                seq_num <= cur_desc.seq_num;
                prio    <= cur_desc.prio;
            end
        end
    end

    assign start = (pulse_cnt != '0);

    // live view of the served descriptor
    assign need_ack      = cur_desc.need_ack;
    assign retrans_limit = cur_desc.retrans_limit;

endmodule

/* rtl/tx_pkt_buf.sv */
// simple dual-port packet buffer, one write port and one registered read port
`timescale 1ns/10ps

module tx_pkt_buf import tx_bit_pkg::*; (
    input  logic      clk,
    input  logic      we,
    input  buf_addr_t waddr,
    input  dma_word_t wdata,
    input  buf_addr_t raddr,
    output dma_word_t rdata
);

    // one frame worth of dma words
    dma_word_t mem [2**buf_addr_w];

    // filled by the scheduler copy
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // phy side read with one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* rtl/tx_bit_intf.sv */
// transmit bit interface top, descriptor queues, scheduler and packet buffer
`timescale 1ns/10ps

module tx_bit_intf import tx_bit_pkg::*; (
    input  logic                         clk,
    input  logic                         rstn,
    // dma stream
    input  dma_word_t                    data_from_s_axis,
    input  logic                         emptyn_from_s_axis,
    output logic                         ask_data_from_s_axis,
    // host descriptor path
    input  tx_desc_t                     num_dma_symbol_total,
    input  queue_idx_t                   tx_queue_idx_indication_from_ps,
    input  logic                         s_axis_recv_data_from_high,
    input  logic                         auto_start_mode,
    input  buf_addr_t                    num_dma_symbol_th,
    input  logic [num_queues-1:0]        high_tx_allowed,
    // baseband status
    input  logic                         tx_bb_is_ongoing,
    input  logic                         tx_end_from_acc,
    input  logic                         tx_try_complete,
    output logic                         start,
    output queue_idx_t                   tx_queue_idx,
    output fifo_count_t [num_queues-1:0] num_dma_symbol_fifo_data_count,
    output logic                         tx_pkt_need_ack,
    output logic [3:0]                   tx_pkt_retrans_limit,
    output seq_num_t                     tx_pkt_sn,
    output prio_t                        linux_prio,
    // phy read port
    input  buf_addr_t                    bram_addr,
    output dma_word_t                    bram_data_to_acc
);

    // queues to scheduler
    logic [num_queues-1:0] q_empty;
    logic [num_queues-1:0] q_pop;
    tx_desc_t              q_head;

    // scheduler to buffer
    logic      buf_we;
    buf_addr_t buf_waddr;
    dma_word_t buf_wdata;

    tx_desc_queues i_tx_desc_queues (
        .clk              (clk),
        .rstn             (rstn),
        .recv_done_strobe (s_axis_recv_data_from_high),
        .wr_queue         (tx_queue_idx_indication_from_ps),
        .wr_desc          (num_dma_symbol_total),
        .pop              (q_pop),
        .empty            (q_empty),
        .head             (q_head),
        .counts           (num_dma_symbol_fifo_data_count)
    );

    tx_queue_sched i_tx_queue_sched (
        .clk           (clk),
        .rstn          (rstn),
        .allowed       (high_tx_allowed),
        .empty         (q_empty),
        .pop           (q_pop),
        .head          (q_head),
        .bb_busy       (tx_bb_is_ongoing),
        .tx_end        (tx_end_from_acc),
        .try_complete  (tx_try_complete),
        .auto_start    (auto_start_mode),
        .start_th      (num_dma_symbol_th),
        .s_data        (data_from_s_axis),
        .s_emptyn      (emptyn_from_s_axis),
        .s_ask         (ask_data_from_s_axis),
        .buf_we        (buf_we),
        .buf_waddr     (buf_waddr),
        .buf_wdata     (buf_wdata),
        .queue_idx     (tx_queue_idx),
        .need_ack      (tx_pkt_need_ack),
        .retrans_limit (tx_pkt_retrans_limit),
        .seq_num       (tx_pkt_sn),
        .prio          (linux_prio),
        .start         (start)
    );

    tx_pkt_buf i_tx_pkt_buf (
        .clk   (clk),
        .we    (buf_we),
        .waddr (buf_waddr),
        .wdata (buf_wdata),
        .raddr (bram_addr),
        .rdata (bram_data_to_acc)
    );

endmodule

/* bench/tx_bit_checker.sv */
// checker: stream capture, start pulse timing, frame fields, counts and buffer readback
`timescale 1ns/10ps

module tx_bit_checker import tx_bit_pkg::*; (
    input  logic                         clk,
    input  logic                         rstn,
    // dut side
    input  logic                         ask,
    input  logic                         emptyn,
    input  dma_word_t                    s_data,
    input  logic                         start,
    input  queue_idx_t                   queue_idx,
    input  fifo_count_t [num_queues-1:0] counts,
    input  logic                         need_ack,
    input  logic [3:0]                   retrans_limit,
    input  seq_num_t                     sn,
    input  prio_t                        prio,
    input  buf_addr_t                    bram_addr,
    input  dma_word_t                    bram_data,
    // expectations from the bench
    input  tx_desc_t                     exp_desc,
    input  queue_idx_t                   exp_queue,
    input  buf_addr_t                    exp_th,
    input  logic                         exp_auto,
    input  fifo_count_t [num_queues-1:0] exp_counts,
    input  logic                         frame_start,
    input  logic                         count_chk,
    input  logic                         frame_done,
    input  logic                         rd_req,
    input  logic                         report_req,
    output int                           errors
);

    int checks = 0;
    int err_cnt = 0;
    // rising edges seen so far
    int cyc = 0;
    // per-frame bookkeeping
    int acc_cnt = 0;
    int th_cyc = -1;
    int start_first = -1;
    int start_cnt = 0;
    bit rst_checked = 1'b0;
    // readback in flight
    bit rd_pend = 1'b0;
    buf_addr_t rd_idx;
    // words as they crossed the stream handshake
    dma_word_t got [2**buf_addr_w];

    assign errors = err_cnt;

    task automatic compare_value(input string what, input logic [63:0] act,
                                 input logic [63:0] exp);
        checks++;
        if (act !== exp) begin
            err_cnt++;
            $display("Fail %0t: %s is %0h, expected %0h", $time, what, act, exp);
        end
    endtask

    task automatic check_frame();
        int exp_start;
        // pulse only when enabled and the threshold word exists
        exp_start = 0;
        if (exp_auto && int'(exp_th) < int'(exp_desc.num_symbol)) begin
            exp_start = start_pulse_len;
        end
        compare_value("accepted words", 64'(acc_cnt), 64'(exp_desc.num_symbol));
        compare_value("start high cycles", 64'(start_cnt), 64'(exp_start));
        // write one cycle after the word, start one cycle after the write
        if (exp_start != 0) begin
            compare_value("start delay after threshold word", 64'(start_first - th_cyc), 64'd2);
        end
        compare_value("tx_queue_idx", 64'(queue_idx), 64'(exp_queue));
        compare_value("tx_pkt_need_ack", 64'(need_ack), 64'(exp_desc.need_ack));
        compare_value("tx_pkt_retrans_limit", 64'(retrans_limit), 64'(exp_desc.retrans_limit));
        compare_value("tx_pkt_sn", 64'(sn), 64'(exp_desc.seq_num));
        compare_value("linux_prio", 64'(prio), 64'(exp_desc.prio));
    endtask

    always @(posedge clk) begin
        cyc++;
        // first edge out of reset
        if (rstn && !rst_checked) begin
            rst_checked = 1'b1;
            compare_value("ask after reset", 64'(ask), 64'd0);
            compare_value("start after reset", 64'(start), 64'd0);
            compare_value("tx_queue_idx after reset", 64'(queue_idx), 64'd0);
            compare_value("tx_pkt_sn after reset", 64'(sn), 64'd0);
            for (int q = 0; q < num_queues; q++) begin
                compare_value("queue count after reset", 64'(counts[q]), 64'd0);
            end
        end
        if (frame_start) begin
            acc_cnt = 0;
            th_cyc = -1;
            start_first = -1;
            start_cnt = 0;
        end
        // a word moves whenever ask and emptyn meet
        if (ask && emptyn) begin
            if (acc_cnt == int'(exp_th)) begin
                th_cyc = cyc;
            end
            got[buf_addr_t'(acc_cnt)] = s_data;
            acc_cnt++;
        end
        if (start) begin
            if (start_first < 0) begin
                start_first = cyc;
            end
            start_cnt++;
        end
        if (count_chk) begin
            for (int q = 0; q < num_queues; q++) begin
                compare_value("queue count", 64'(counts[q]), 64'(exp_counts[q]));
            end
        end
        if (frame_done) begin
            check_frame();
        end
        // read data answers one edge after the address
        if (rd_pend) begin
            compare_value("buffer word", bram_data, got[rd_idx]);
        end
        rd_pend = rd_req;
        rd_idx = bram_addr;
        if (report_req) begin
            $display("checker: %0d checks, %0d errors", checks, err_cnt);
        end
    end

endmodule

/* bench/tb_tx_bit_intf.sv */
// testbench top: clock, reset, lfsr, frame table, stimulus loop, dut and checker
`timescale 1ns/10ps

module tb_tx_bit_intf import tx_bit_pkg::*; ();

    // one frame per row
    typedef struct packed {
        queue_idx_t  queue;
        num_symbol_t num_symbol;
        buf_addr_t   th;
        logic        auto_st;
        logic [3:0]  allowed;
        seq_num_t    sn;
        prio_t       prio;
        logic        need_ack;
        logic [3:0]  retrans_limit;
    } frame_row_t;

    localparam int num_rows = 5;

    frame_row_t rows [num_rows];

    logic clk;
    logic rstn;
    dma_word_t data_from_s_axis;
    logic emptyn_from_s_axis;
    logic ask_data_from_s_axis;
    tx_desc_t num_dma_symbol_total;
    queue_idx_t tx_queue_idx_indication_from_ps;
    logic s_axis_recv_data_from_high;
    logic auto_start_mode;
    buf_addr_t num_dma_symbol_th;
    logic [num_queues-1:0] high_tx_allowed;
    logic tx_bb_is_ongoing;
    logic tx_end_from_acc;
    logic tx_try_complete;
    logic start;
    queue_idx_t tx_queue_idx;
    fifo_count_t [num_queues-1:0] num_dma_symbol_fifo_data_count;
    logic tx_pkt_need_ack;
    logic [3:0] tx_pkt_retrans_limit;
    seq_num_t tx_pkt_sn;
    prio_t linux_prio;
    buf_addr_t bram_addr;
    dma_word_t bram_data_to_acc;

    // expectations handed to the checker
    tx_desc_t exp_desc;
    queue_idx_t exp_queue;
    buf_addr_t exp_th;
    logic exp_auto;
    fifo_count_t [num_queues-1:0] exp_counts;
    logic frame_start;
    logic count_chk;
    logic frame_done;
    logic rd_req;
    logic report_req;
    int errors;

    logic [31:0] lfsr;
    bit hung;
    string hung_on;

    tx_bit_intf i_tx_bit_intf (.*);

    tx_bit_checker i_tx_bit_checker (
        .clk           (clk),
        .rstn          (rstn),
        .ask           (ask_data_from_s_axis),
        .emptyn        (emptyn_from_s_axis),
        .s_data        (data_from_s_axis),
        .start         (start),
        .queue_idx     (tx_queue_idx),
        .counts        (num_dma_symbol_fifo_data_count),
        .need_ack      (tx_pkt_need_ack),
        .retrans_limit (tx_pkt_retrans_limit),
        .sn            (tx_pkt_sn),
        .prio          (linux_prio),
        .bram_addr     (bram_addr),
        .bram_data     (bram_data_to_acc),
        .exp_desc      (exp_desc),
        .exp_queue     (exp_queue),
        .exp_th        (exp_th),
        .exp_auto      (exp_auto),
        .exp_counts    (exp_counts),
        .frame_start   (frame_start),
        .count_chk     (count_chk),
        .frame_done    (frame_done),
        .rd_req        (rd_req),
        .report_req    (report_req),
        .errors        (errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1, new bit enters at bit 0
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output dma_word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[dma_word_w-2:0], lfsr[0]};
        end
    endtask

    // descriptor word as the host writes it
    function automatic tx_desc_t row_desc(input frame_row_t r);
        return '{r.prio, r.sn, 2'b00, r.retrans_limit, r.need_ack, r.num_symbol};
    endfunction

    task automatic load_rows();
        // q0 twice, q2 with q1 masked off, then q1, then q3 with th past the end
        rows[0] = '{2'd0, 13'd5, 10'd2, 1'b1, 4'hf, 10'd17, 2'd1, 1'b1, 4'd3};
        rows[1] = '{2'd0, 13'd3, 10'd1, 1'b0, 4'hf, 10'd18, 2'd1, 1'b0, 4'd7};
        rows[2] = '{2'd2, 13'd4, 10'd3, 1'b1, 4'hd, 10'd300, 2'd2, 1'b1, 4'd15};
        rows[3] = '{2'd1, 13'd8, 10'd0, 1'b1, 4'hf, 10'd511, 2'd0, 1'b0, 4'd1};
        rows[4] = '{2'd3, 13'd6, 10'd9, 1'b1, 4'h8, 10'd1023, 2'd3, 1'b1, 4'd0};
    endtask

    task automatic enqueue(input frame_row_t r);
        num_dma_symbol_total = row_desc(r);
        tx_queue_idx_indication_from_ps = r.queue;
        s_axis_recv_data_from_high = 1'b1;
        repeat (2) @(negedge clk);
        // falling edge is the write request
        s_axis_recv_data_from_high = 1'b0;
        exp_counts[r.queue] = exp_counts[r.queue] + 1'b1;
        // edge seen, write a cycle later, count a cycle after that
        repeat (2) @(negedge clk);
        count_chk = 1'b1;
        @(negedge clk);
        count_chk = 1'b0;
    endtask

    task automatic wait_ask_high(input int limit);
        int n;
        n = 0;
        while (!ask_data_from_s_axis && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!ask_data_from_s_axis) begin
            hung = 1'b1;
            hung_on = "ask to rise";
        end
    endtask

    task automatic serve(input frame_row_t r);
        dma_word_t word;
        logic offered;
        int n;
        exp_desc = row_desc(r);
        exp_queue = r.queue;
        exp_th = r.th;
        exp_auto = r.auto_st;
        high_tx_allowed = r.allowed;
        auto_start_mode = r.auto_st;
        num_dma_symbol_th = r.th;
        frame_start = 1'b1;
        @(negedge clk);
        frame_start = 1'b0;
        // let the scheduler pick
        tx_bb_is_ongoing = 1'b0;
        wait_ask_high(20);
        if (hung) begin
            return;
        end
        // keep the next frame parked until readback is over
        tx_bb_is_ongoing = 1'b1;
        exp_counts[r.queue] = exp_counts[r.queue] - 1'b1;
        count_chk = 1'b1;
        n = 0;
        offered = 1'b1;
        while (ask_data_from_s_axis && n < 500) begin
            // new word only once the old one was taken
            if (offered) begin
                draw_bits(dma_word_w, word);
                data_from_s_axis = word;
            end
            draw_bits(2, word);
            emptyn_from_s_axis = |word[1:0];
            // ask holds until the next rising edge
            offered = ask_data_from_s_axis && emptyn_from_s_axis;
            @(negedge clk);
            count_chk = 1'b0;
            n++;
        end
        emptyn_from_s_axis = 1'b0;
        count_chk = 1'b0;
        if (ask_data_from_s_axis) begin
            hung = 1'b1;
            hung_on = "ask to fall";
            return;
        end
        // room for the start pulse to run out
        repeat (start_pulse_len + 2) @(negedge clk);
        tx_end_from_acc = 1'b1;
        @(negedge clk);
        tx_end_from_acc = 1'b0;
        tx_try_complete = 1'b1;
        @(negedge clk);
        tx_try_complete = 1'b0;
        frame_done = 1'b1;
        @(negedge clk);
        frame_done = 1'b0;
        // phy side readback
        for (int k = 0; k < int'(r.num_symbol); k++) begin
            bram_addr = buf_addr_t'(k);
            rd_req = 1'b1;
            @(negedge clk);
        end
        rd_req = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        data_from_s_axis = '0;
        emptyn_from_s_axis = 1'b0;
        num_dma_symbol_total = '0;
        tx_queue_idx_indication_from_ps = '0;
        s_axis_recv_data_from_high = 1'b0;
        auto_start_mode = 1'b0;
        num_dma_symbol_th = '0;
        high_tx_allowed = '0;
        // baseband busy holds the scheduler while queues fill
        tx_bb_is_ongoing = 1'b1;
        tx_end_from_acc = 1'b0;
        tx_try_complete = 1'b0;
        bram_addr = '0;
        exp_desc = '0;
        exp_queue = '0;
        exp_th = '0;
        exp_auto = 1'b0;
        exp_counts = '0;
        frame_start = 1'b0;
        count_chk = 1'b0;
        frame_done = 1'b0;
        rd_req = 1'b0;
        report_req = 1'b0;
        hung = 1'b0;
        hung_on = "";
        lfsr = 32'h6ef;
        load_rows();
        rstn = 1'b0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        // highest queue first, service order must come from the scheduler
        for (int q = num_queues - 1; q >= 0; q--) begin
            for (int r = 0; r < num_rows; r++) begin
                if (int'(rows[r].queue) == q) begin
                    enqueue(rows[r]);
                end
            end
        end
        for (int r = 0; r < num_rows; r++) begin
            if (!hung) begin
                serve(rows[r]);
            end
        end
        report_req = 1'b1;
        @(negedge clk);
        report_req = 1'b0;
        @(negedge clk);
        if (!hung && errors == 0) begin
            $display("Everything OK");
        end else begin
            if (hung) begin
                $display("Run stopped, timed out waiting for %s", hung_on);
            end
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* tx_bit_intf.f */
rtl/tx_bit_pkg.sv
rtl/tx_desc_fifo.sv
rtl/tx_desc_queues.sv
rtl/tx_queue_sched.sv
rtl/tx_pkt_buf.sv
rtl/tx_bit_intf.sv
bench/tx_bit_checker.sv
bench/tb_tx_bit_intf.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the tx_bit_intf testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -f tx_bit_intf.f --top-module tb_tx_bit_intf -o sim_tx_bit_intf
./obj_dir/sim_tx_bit_intf > sim.log 2>&1
cat sim.log

if grep -qx "Everything OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
